// ==== hdl/gfx_pkg.sv ====
/* types, palette and cube geometry shared by the cube drawing design
   and the testbench model; import where needed */
package gfx_pkg;

    typedef logic signed [15:0] coord_t;  // screen or framebuffer position
    typedef logic [1:0] cidx_t;           // palette index
    typedef logic [3:0] chan_t;           // one colour channel

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
    } line_t;

    localparam rgb_t PALETTE [4] = '{
        '{4'h0, 4'h0, 4'h0},  // black background
        '{4'h4, 4'h4, 4'h4},  // dark grey
        '{4'h0, 4'hf, 4'h0},  // green
        '{4'hf, 4'hf, 4'hf}   // white
    };

    localparam int LINE_CNT = 9;

    // front face, back edges and the joining diagonals
    localparam line_t CUBE_LINES [LINE_CNT] = '{
        '{ 65, 45, 115, 45},
        '{115, 45, 115, 95},
        '{115, 95,  65, 95},
        '{ 65, 95,  65, 45},
        '{ 65, 95,  45, 75},
        '{ 45, 75,  45, 25},
        '{ 45, 25,  65, 45},
        '{ 45, 25,  95, 25},
        '{ 95, 25, 115, 45}
    };

    localparam cidx_t LINE_COLOUR = 2'd2;  // green

endpackage

// ==== hdl/line_if.sv ====
/* line request channel from the scene sequencer to the rasteriser,
   and the pixel write channel from the rasteriser to the framebuffer */
`timescale 1ns/10ps

interface line_if;
    import gfx_pkg::*;

    logic valid;   // held until ready
    logic ready;
    line_t seg;    // stable while valid waits
    cidx_t cidx;

    modport scene (output valid, output seg, output cidx, input ready);
    modport drawer (input valid, input seg, input cidx, output ready);
endinterface

interface pix_if;
    import gfx_pkg::*;

    // no back-pressure, the sink takes a write every cycle
    logic valid;
    coord_t x;
    coord_t y;
    cidx_t cidx;

    modport source (output valid, output x, output y, output cidx);
    modport sink (input valid, input x, input y, input cidx);
endinterface

// ==== hdl/display_timings.sv ====
/* free-running display counters; decodes screen position, active-low
   syncs, data enable and a one-cycle pulse at the start of each frame */
`timescale 1ns/10ps

module display_timings #(
    parameter int H_RES  = 640,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_RES  = 480,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic            clk_pix,
    input  logic            reset,
    output gfx_pkg::coord_t sx,
    output gfx_pkg::coord_t sy,
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output logic            frame
);

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525
    localparam int HS_STA  = H_RES + H_FP;
    localparam int HS_END  = HS_STA + H_SYNC;
    localparam int VS_STA  = V_RES + V_FP;
    localparam int VS_END  = VS_STA + V_SYNC;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_TOTAL - 1) begin  // end of line
            sx <= '0;
            if (sy == V_TOTAL - 1) begin
                sy <= '0;
            end else begin
                sy <= sy + 16'sd1;
            end
        end else begin
            sx <= sx + 16'sd1;
        end
    end

    always_comb begin
        hsync = !(sx >= HS_STA && sx < HS_END);  // active low
        vsync = !(sy >= VS_STA && sy < VS_END);
        de    = sx < H_RES && sy < V_RES;
        frame = sx == 0 && sy == 0;
    end

endmodule

// ==== hdl/cube_scene.sv ====
/* scene sequencer; on start it hands the cube segments one at a time
   to the rasteriser and holds busy until the last one is drawn */
`timescale 1ns/10ps

module cube_scene (
    input  logic   clk_pix,
    input  logic   reset,
    input  logic   start,
    output logic   busy,
    line_if.scene  req
);
    import gfx_pkg::*;

    localparam int IDX_W = $clog2(LINE_CNT);

    typedef enum logic [1:0] {
        IDLE,   // nothing drawn since reset
        ISSUE,  // request waiting for the rasteriser
        WAIT,   // segment being drawn
        DONE    // picture complete, start redraws
    } state_t;

    state_t state;
    logic [IDX_W-1:0] line_idx;
    logic last_line;

    assign last_line = line_idx == IDX_W'(LINE_CNT - 1);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state    <= IDLE;
            line_idx <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state    <= ISSUE;
                        line_idx <= '0;
                    end
                end
                ISSUE: if (req.ready) state <= WAIT;  // transfer this cycle
                WAIT: begin
                    if (req.ready) begin  // rasteriser idle again
                        if (last_line) begin
                            state <= DONE;
                        end else begin
                            line_idx <= line_idx + 1'b1;
                            state    <= ISSUE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy      = state == ISSUE || state == WAIT;
    assign req.valid = state == ISSUE;
    assign req.seg   = CUBE_LINES[line_idx];
    assign req.cidx  = LINE_COLOUR;

    // a pending request holds still until the drawer takes it
    assert property (@(posedge clk_pix) disable iff (reset)
        req.valid && !req.ready |=> req.valid && $stable(req.seg))
        else $error("segment changed before transfer");

endmodule

// ==== hdl/draw_line.sv ====
/* Bresenham line rasteriser; takes one segment per request and emits
   one pixel write per cycle from start to end point inclusive */
`timescale 1ns/10ps

module draw_line #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic   clk_pix,
    input  logic   reset,
    line_if.drawer req,
    pix_if.source  pix
);
    import gfx_pkg::*;

    typedef logic signed [17:0] err_t;  // wide enough for any coord_t span

    logic   drawing;
    logic   accept;
    coord_t x, y;            // current pixel
    coord_t x_end, y_end;
    logic   step_right;      // x increases
    logic   step_down;       // y increases
    cidx_t  cidx_q;
    err_t   dx, dy;          // dy held negative
    err_t   err;
    err_t   diff_x, diff_y;
    err_t   abs_x, abs_y;
    logic signed [18:0] e2;
    logic   step_x, step_y;
    logic   at_end;

    function automatic logic on_fb(coord_t px, coord_t py);
        return px >= 0 && px < FB_WIDTH && py >= 0 && py < FB_HEIGHT;
    endfunction

    always_comb begin
        accept = req.valid && req.ready;
        diff_x = err_t'(req.seg.x1) - err_t'(req.seg.x0);
        diff_y = err_t'(req.seg.y1) - err_t'(req.seg.y0);
        abs_x  = diff_x < 0 ? -diff_x : diff_x;
        abs_y  = diff_y < 0 ? -diff_y : diff_y;
        e2     = {err, 1'b0};
        step_x = e2 >= dy;
        step_y = e2 <= dx;
        at_end = x == x_end && y == y_end;
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            drawing <= 1'b0;
        end else if (accept) begin
            drawing <= 1'b1;
        end else if (drawing && at_end) begin
            drawing <= 1'b0;  // last pixel goes out this cycle
        end
    end

    always_ff @(posedge clk_pix) begin
        if (accept) begin
            x          <= req.seg.x0;
            y          <= req.seg.y0;
            x_end      <= req.seg.x1;
            y_end      <= req.seg.y1;
            step_right <= diff_x >= 0;
            step_down  <= diff_y >= 0;
            dx         <= abs_x;
            dy         <= -abs_y;
            err        <= abs_x - abs_y;
            cidx_q     <= req.cidx;
        end else if (drawing && !at_end) begin
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
            if (step_x) x <= step_right ? x + 16'sd1 : x - 16'sd1;
            if (step_y) y <= step_down ? y + 16'sd1 : y - 16'sd1;
        end
    end

    assign req.ready = !drawing;
    assign pix.valid = drawing;
    assign pix.x     = x;
    assign pix.y     = y;
    assign pix.cidx  = cidx_q;

    // walk never steps past the end point
    assert property (@(posedge clk_pix) disable iff (reset)
        drawing |-> (step_right ? x <= x_end : x >= x_end)
                 && (step_down ? y <= y_end : y >= y_end))
        else $error("pixel walk went past the end point");

    assert property (@(posedge clk_pix) disable iff (reset)
        accept |-> on_fb(req.seg.x0, req.seg.y0) && on_fb(req.seg.x1, req.seg.y1))
        else $error("segment end point outside the framebuffer");

endmodule

// ==== hdl/framebuffer.sv ====
/* indexed-colour framebuffer; stores clipped pixel writes and scans the
   image out scaled up, with colour aligned to the delayed syncs */
`timescale 1ns/10ps

module framebuffer #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int FB_SCALE  = 4
) (
    input  logic            clk_pix,
    input  logic            reset,
    pix_if.sink             pix,
    input  gfx_pkg::coord_t sx,
    input  gfx_pkg::coord_t sy,
    input  logic            hsync_in,
    input  logic            vsync_in,
    input  logic            de_in,
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output gfx_pkg::chan_t  red,
    output gfx_pkg::chan_t  green,
    output gfx_pkg::chan_t  blue
);
    import gfx_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_W    = $clog2(FB_PIXELS);

    cidx_t fb_mem [FB_PIXELS] = '{default: '0};  // starts all background

    logic              x_ok, y_ok;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    rgb_t              colour;

    always_comb begin
        x_ok    = pix.x >= 0 && pix.x < FB_WIDTH;
        y_ok    = pix.y >= 0 && pix.y < FB_HEIGHT;
        wr_en   = pix.valid && x_ok && y_ok;
        wr_addr = wr_en ? ADDR_W'(int'(pix.y) * FB_WIDTH + int'(pix.x)) : '0;
        // screen position down to framebuffer pixel, only inside the picture
        rd_addr = de_in ?
            ADDR_W'((int'(sy) / FB_SCALE) * FB_WIDTH + int'(sx) / FB_SCALE) : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (wr_en) fb_mem[wr_addr] <= pix.cidx;
    end

    // one stage of read plus palette, syncs follow along
    always_ff @(posedge clk_pix) begin
        hsync  <= hsync_in;
        vsync  <= vsync_in;
        de     <= de_in;
        colour <= de_in ? PALETTE[fb_mem[rd_addr]] : '0;  // blank outside de
    end

    assign red   = colour.red;
    assign green = colour.green;
    assign blue  = colour.blue;

    // the drawer never needs clipping for the cube scene
    assert property (@(posedge clk_pix) disable iff (reset)
        pix.valid |-> x_ok && y_ok)
        else $error("pixel write outside the framebuffer");

endmodule

// ==== hdl/cube_top.sv ====
/* wireframe cube display; drawing starts on a start pulse and the
   picture is scanned out as a 640x480 stream on clk_pix */
`timescale 1ns/10ps

module cube_top #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int FB_SCALE  = 4,
    parameter int H_RES     = 640,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_RES     = 480,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33
) (
    input  logic           clk_pix,
    input  logic           reset,
    input  logic           start,
    output logic           busy,
    output logic           hsync,
    output logic           vsync,
    output logic           de,
    output gfx_pkg::chan_t red,
    output gfx_pkg::chan_t green,
    output gfx_pkg::chan_t blue
);
    import gfx_pkg::*;

    coord_t sx, sy;                   // screen position
    logic   tim_hsync, tim_vsync, tim_de;

    line_if line_req ();
    pix_if  pix_wr ();

    display_timings #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) i_display_timings (
        .clk_pix, .reset, .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de),
        .frame()  // spare, the scene is started externally
    );

    cube_scene i_cube_scene (.clk_pix, .reset, .start, .busy, .req(line_req));

    draw_line #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_draw_line (
        .clk_pix, .reset, .req(line_req), .pix(pix_wr)
    );

    framebuffer #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) i_framebuffer (
        .clk_pix, .reset, .pix(pix_wr), .sx, .sy,
        .hsync_in(tim_hsync), .vsync_in(tim_vsync), .de_in(tim_de),
        .hsync, .vsync, .de, .red, .green, .blue
    );

endmodule

// ==== test/tb_model.svh ====
/* reference picture for the cube testbench, rasterised once from the
   line table; included inside the testbench module */
cidx_t ref_fb [FB_W][FB_H];
bit    ref_built;

// plain Bresenham walk, both end points inclusive
function automatic void plot_line(line_t ln);
    int x, y, dx, dy, step_x, step_y, err, e2;
    x      = ln.x0;
    y      = ln.y0;
    dx     = ln.x1 > ln.x0 ? ln.x1 - ln.x0 : ln.x0 - ln.x1;
    dy     = ln.y1 > ln.y0 ? ln.y0 - ln.y1 : ln.y1 - ln.y0;  // kept negative
    step_x = ln.x1 > ln.x0 ? 1 : -1;
    step_y = ln.y1 > ln.y0 ? 1 : -1;
    err    = dx + dy;
    while (1'b1) begin
        ref_fb[x][y] = LINE_COLOUR;
        if (x == ln.x1 && y == ln.y1) break;
        e2 = 2 * err;
        if (e2 >= dy) begin
            err += dy;
            x   += step_x;
        end
        if (e2 <= dx) begin
            err += dx;
            y   += step_y;
        end
    end
endfunction

// colour of one framebuffer pixel once the cube is drawn
function automatic rgb_t expected_rgb(int fx, int fy);
    if (!ref_built) begin
        foreach (ref_fb[i, j]) ref_fb[i][j] = '0;  // memory starts as background
        for (int n = 0; n < LINE_CNT; n++) plot_line(CUBE_LINES[n]);
        ref_built = 1;
    end
    return PALETTE[ref_fb[fx][fy]];
endfunction

// ==== test/tb_cube.sv ====
/* testbench for the cube display; draws the cube twice and checks sync
   timing and every scanned-out pixel against the reference picture */
`timescale 1ns/10ps

module tb_cube;
    import gfx_pkg::*;

    localparam int FB_W     = 160;
    localparam int FB_H     = 120;
    localparam int FB_SCALE = 4;
    localparam int H_RES    = 640;
    localparam int HS_STA   = 656;
    localparam int HS_END   = 752;
    localparam int H_TOTAL  = 800;
    localparam int V_RES    = 480;
    localparam int VS_STA   = 490;
    localparam int VS_END   = 492;
    localparam int V_TOTAL  = 525;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES;  // five frames of test, one spare
    localparam int DRAW_LIMIT     = 400;  // 369 pixels plus two handshake cycles per segment
    localparam int RESTART_AT     = 100;  // well inside the drawing

    logic  clk_pix = 0;
    logic  reset, start;
    logic  busy, hsync, vsync, de;
    chan_t red, green, blue;

    int     m_x, m_y;       // DUT counters
    int     out_x, out_y;   // position of the pixel now at the ports
    bit     active;
    bit     pic_ok, drawn;
    int     frame_cnt, good_frames;
    logic   prev_hs = 1'b1;
    logic   prev_vs = 1'b1;
    bit     seen_vs;
    int     hs_cnt, de_cnt;
    logic   exp_de;
    int     cycles;
    integer seed = 32'h8051;

    `include "tb_model.svh"

    cube_top #(
        .FB_WIDTH(FB_W), .FB_HEIGHT(FB_H), .FB_SCALE(FB_SCALE),
        .H_RES(H_RES), .H_FP(HS_STA - H_RES), .H_SYNC(HS_END - HS_STA),
        .H_BP(H_TOTAL - HS_END), .V_RES(V_RES), .V_FP(VS_STA - V_RES),
        .V_SYNC(VS_END - VS_STA), .V_BP(V_TOTAL - VS_END)
    ) i_cube_top (
        .clk_pix, .reset, .start, .busy, .hsync, .vsync, .de, .red, .green, .blue
    );

    initial begin
        forever #4 clk_pix = ~clk_pix;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rgb(rgb_t exp, rgb_t act);
        if (act !== exp) begin
            $display("Error at %0t: rgb at (%0d,%0d) expected %h, got %h",
                     $time, out_x, out_y, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // ports lag the counters by one cycle
    always @(posedge clk_pix) begin
        active <= !reset;
        out_x  <= m_x;
        out_y  <= m_y;
        if (reset) begin
            m_x <= 0;
            m_y <= 0;
        end else if (m_x == H_TOTAL - 1) begin
            m_x <= 0;
            m_y <= m_y == V_TOTAL - 1 ? 0 : m_y + 1;
        end else begin
            m_x <= m_x + 1;
        end
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    always @(negedge clk_pix) begin
        if (active) begin
            exp_de = out_x < H_RES && out_y < V_RES;
            check_bit("hsync", !(out_x >= HS_STA && out_x < HS_END), hsync);
            check_bit("vsync", !(out_y >= VS_STA && out_y < VS_END), vsync);
            check_bit("de", exp_de, de);
            if (out_x == 0 && out_y == 0) begin  // new frame at the ports
                if (pic_ok && frame_cnt > 0) good_frames <= good_frames + 1;
                frame_cnt <= frame_cnt + 1;
                pic_ok = 1;
            end
            if (busy) begin
                pic_ok = 0;  // picture in flux
                drawn  = 1;
            end
            if (!exp_de) begin
                check_rgb('0, {red, green, blue});
            end else if (pic_ok) begin
                check_rgb(drawn ? expected_rgb(out_x / FB_SCALE, out_y / FB_SCALE)
                                : PALETTE[0], {red, green, blue});
            end
            if (de) de_cnt++;
            if (prev_hs && !hsync) begin
                if (de_cnt != 0) check_count("de per line", H_RES, de_cnt);
                de_cnt = 0;
                hs_cnt++;
            end
            if (prev_vs && !vsync) begin
                if (seen_vs) check_count("hsync per frame", V_TOTAL, hs_cnt);
                seen_vs = 1;
                hs_cnt  = 0;
            end
            prev_hs = hsync;
            prev_vs = vsync;
        end
    end

    task automatic wait_for_frame(int n);
        while (frame_cnt < n) @(negedge clk_pix);
    endtask

    // start pulse, a second one while busy if asked, then wait for the end
    task automatic draw_cube(bit restart);
        int n;
        start = 1'b1;
        @(negedge clk_pix);
        start = 1'b0;
        check_bit("busy", 1'b1, busy);
        n = 0;
        while (busy) begin
            start = restart && n == RESTART_AT;  // ignored while drawing
            @(negedge clk_pix);
            n++;
            if (n > DRAW_LIMIT) begin
                $display("busy still high %0d cycles after start", DRAW_LIMIT);
                abort_run();
            end
        end
        start = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        repeat (2) @(negedge clk_pix);
        reset = 1'b0;
        @(negedge clk_pix);
        check_bit("busy", 1'b0, busy);
        wait_for_frame(2);  // frame 1 shows the cleared memory
        draw_cube(1'b1);
        wait_for_frame(frame_cnt + 2);
        repeat (($random(seed) & 255) + 16) @(negedge clk_pix);
        draw_cube(1'b0);
        wait_for_frame(frame_cnt + 2);
        if (good_frames == 3) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("only %0d of 3 frames were compared", good_frames);
            abort_run();
        end
    end

endmodule

// ==== tb.f ====
+incdir+test
hdl/gfx_pkg.sv
hdl/line_if.sv
hdl/display_timings.sv
hdl/cube_scene.sv
hdl/draw_line.sv
hdl/framebuffer.sv
hdl/cube_top.sv
test/tb_cube.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cube testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_cube -o sim_cube

# a failed check ends the simulator with an error, the log search decides
./obj_dir/sim_cube > sim.log 2>&1 || true
cat sim.log
grep -q "TEST PASSED" sim.log
